/* lspcPkg.sv */
// LSPC shared definitions
package lspcPkg;

	// ====================
	// Fixed widths

	// CPU data word and VRAM word
	localparam int WORD_BITS = 16;
	// Auto-animation tile counter
	localparam int AA_BITS = 3;
	// Raster line as seen in the mode read word
	localparam int RASTER_BITS = 9;

	// ====================
	// Register map

	// Word registers, CPU address bits 2:1
	typedef enum logic [1:0] {
		REG_VRAMADDR = 2'd0,
		REG_VRAMRW   = 2'd1,
		REG_VRAMMOD  = 2'd2,
		REG_LSPCMODE = 2'd3
	} regSelT;

	// One CPU bus request, sampled on CLK
	typedef struct packed {
		regSelT                sel;
		logic                  wr;
		logic                  rd;
		logic [WORD_BITS-1:0]  wrData;
	} cpuBusT;

	// ====================
	// VRAM command channel

	// Set isWrite writes at the pointer, clear loads the pointer
	typedef struct packed {
		logic                  isWrite;
		logic [WORD_BITS-1:0]  data;
	} vramCmdT;

	// Mode register write word, raw or split into fields
	typedef union packed {
		logic [WORD_BITS-1:0] raw;
		struct packed {
			logic [7:0] aaSpeed;
			logic [7:0] reserved;
		} fields;
	} lspcModeT;

endpackage

/* lspcRegs.sv */
// CPU register block
module lspcRegs #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                                CLK,
	input  logic                                nRESETP,
	input  lspcPkg::cpuBusT                     cpuBus,
	input  logic                                creditReturn,
	input  logic [lspcPkg::WORD_BITS-1:0]       readLatch,
	input  logic [lspcPkg::RASTER_BITS-1:0]     rasterLine,
	input  logic [lspcPkg::AA_BITS-1:0]         aaCount,
	output logic                                cpuWait,
	output logic [lspcPkg::WORD_BITS-1:0]       rdData,
	output logic                                cmdValid,
	output lspcPkg::vramCmdT                    cmd,
	output logic [lspcPkg::WORD_BITS-1:0]       vramMod,
	output logic [7:0]                          aaSpeed
);

	// Credit count runs 0..QUEUE_DEPTH
	localparam int CREDIT_BITS = $clog2(QUEUE_DEPTH + 1);
	// Zero gap between raster and tile fields in the mode read word
	localparam int PAD_BITS = lspcPkg::WORD_BITS - lspcPkg::RASTER_BITS - lspcPkg::AA_BITS;

	logic [CREDIT_BITS-1:0]              credits;
	logic                                vramWrReq;
	logic                                haveCredit;
	logic                                modWr;
	logic                                modeWr;
	lspcPkg::lspcModeT                   modeReg;
	logic [lspcPkg::WORD_BITS-1:0]       modeRdWord;
	logic [lspcPkg::WORD_BITS-1:0]       rdMux;

	// ====================
	// Write decode

	// Address and data writes both go through the VRAM queue
	assign vramWrReq = cpuBus.wr &&
		(cpuBus.sel == lspcPkg::REG_VRAMADDR || cpuBus.sel == lspcPkg::REG_VRAMRW);
	assign haveCredit = credits != '0;

	// Stall the CPU only on a VRAM write with no slot left in the queue
	assign cpuWait = vramWrReq && !haveCredit;

	// Local registers never stall
	assign modWr = cpuBus.wr && cpuBus.sel == lspcPkg::REG_VRAMMOD;
	assign modeWr = cpuBus.wr && cpuBus.sel == lspcPkg::REG_LSPCMODE;

	// Command goes out in the cycle the write is accepted
	assign cmdValid = vramWrReq && haveCredit;
	assign cmd.isWrite = cpuBus.sel == lspcPkg::REG_VRAMRW;
	assign cmd.data = cpuBus.wrData;

	// ====================
	// Credit counter

	// One spent per command, one back per queue pop
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			credits <= CREDIT_BITS'(QUEUE_DEPTH);
		end else begin
			credits <= credits - CREDIT_BITS'(cmdValid) + CREDIT_BITS'(creditReturn);
		end
	end

	// ====================
	// Modulo and mode registers

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramMod <= '0;
			modeReg.raw <= '0;
		end else begin
			if (modWr) begin
				vramMod <= cpuBus.wrData;
			end
			// Whole word kept, speed taken from the field view
			if (modeWr) begin
				modeReg.raw <= cpuBus.wrData;
			end
		end
	end

	assign aaSpeed = modeReg.fields.aaSpeed;

	// ====================
	// Read path

	// Raster line on top, tile count at the bottom
	assign modeRdWord = {rasterLine, {PAD_BITS{1'b0}}, aaCount};

	always_comb begin
		case (cpuBus.sel)
			lspcPkg::REG_VRAMMOD:  rdMux = vramMod;
			lspcPkg::REG_LSPCMODE: rdMux = modeRdWord;
			// Both VRAM registers read back the latch
			default:               rdMux = readLatch;
		endcase
	end

	// Data valid the cycle after rd, held until the next read
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			rdData <= '0;
		end else if (cpuBus.rd) begin
			rdData <= rdMux;
		end
	end

endmodule

/* vramPort.sv */
// VRAM access unit
module vramPort #(
	parameter int VRAM_ADDR_BITS = 8,
	parameter int SLOT_PERIOD = 4,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                            CLK,
	input  logic                            nRESETP,
	input  logic                            cmdValid,
	input  lspcPkg::vramCmdT                cmd,
	input  logic [lspcPkg::WORD_BITS-1:0]   vramMod,
	output logic                            creditReturn,
	output logic [lspcPkg::WORD_BITS-1:0]   readLatch
);

	localparam int Q_PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int Q_CNT_BITS = $clog2(QUEUE_DEPTH + 1);
	localparam int SLOT_BITS = (SLOT_PERIOD > 1) ? $clog2(SLOT_PERIOD) : 1;
	localparam int VRAM_WORDS = 1 << VRAM_ADDR_BITS;

	// Command FIFO
	lspcPkg::vramCmdT                queue [QUEUE_DEPTH];
	logic [Q_PTR_BITS-1:0]           qWrPtr;
	logic [Q_PTR_BITS-1:0]           qRdPtr;
	logic [Q_PTR_BITS-1:0]           qWrNext;
	logic [Q_PTR_BITS-1:0]           qRdNext;
	logic [Q_CNT_BITS-1:0]           qCount;
	logic                            qEmpty;
	lspcPkg::vramCmdT                head;

	// Slot sequencer
	logic [SLOT_BITS-1:0]            slotCnt;
	logic                            slotOpen;
	logic                            pop;
	logic                            doWrite;

	// Array and pointer
	logic [lspcPkg::WORD_BITS-1:0]   vram [VRAM_WORDS];
	logic [VRAM_ADDR_BITS-1:0]       pointer;
	logic [VRAM_ADDR_BITS-1:0]       ptrStepped;
	logic                            ptrValid;

	// ====================
	// Queue bookkeeping

	assign qWrNext = (qWrPtr == Q_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : qWrPtr + 1'b1;
	assign qRdNext = (qRdPtr == Q_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : qRdPtr + 1'b1;
	assign qEmpty = qCount == '0;
	assign head = queue[qRdPtr];

	// Credits upstream keep pushes from overflowing
	always_ff @(posedge CLK) begin
		if (cmdValid) begin
			queue[qWrPtr] <= cmd;
		end
	end

	// ====================
	// Slot timing

	// One access slot at the end of every period
	assign slotOpen = slotCnt == SLOT_BITS'(SLOT_PERIOD - 1);
	assign pop = slotOpen && !qEmpty;
	assign doWrite = pop && head.isWrite;

	// Wrapping add, all ones steps back by one
	assign ptrStepped = pointer + vramMod[VRAM_ADDR_BITS-1:0];

	// ====================
	// VRAM array

	always_ff @(posedge CLK) begin
		if (doWrite) begin
			vram[pointer] <= head.data;
		end
	end

	// ====================
	// Control state

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			qWrPtr <= '0;
			qRdPtr <= '0;
			qCount <= '0;
			slotCnt <= '0;
			pointer <= '0;
			ptrValid <= 1'b0;
			creditReturn <= 1'b0;
			readLatch <= '0;
		end else begin
			slotCnt <= slotOpen ? '0 : slotCnt + 1'b1;
			if (cmdValid) begin
				qWrPtr <= qWrNext;
			end
			if (pop) begin
				qRdPtr <= qRdNext;
			end
			qCount <= qCount + Q_CNT_BITS'(cmdValid) - Q_CNT_BITS'(pop);
			// One credit back per command taken out
			creditReturn <= pop;
			if (pop) begin
				ptrValid <= 1'b1;
				// Load pointer or step it after the write
				if (head.isWrite) begin
					pointer <= ptrStepped;
				end else begin
					pointer <= head.data[VRAM_ADDR_BITS-1:0];
				end
			end
			// Idle slot refreshes the latch, once a command has run
			if (slotOpen && qEmpty && ptrValid) begin
				readLatch <= vram[pointer];
			end
		end
	end

endmodule

/* videoTiming.sv */
// Video timing generator
module videoTiming #(
	parameter int LINE_PIXELS = 384,
	parameter int FRAME_LINES = 264,
	parameter int HSYNC_PIXELS = 29,
	parameter int VSYNC_LINES = 8
) (
	input  logic                              CLK,
	input  logic                              nRESETP,
	output logic                              HSYNC,
	output logic                              VSYNC,
	output logic [lspcPkg::RASTER_BITS-1:0]   rasterLine,
	output logic                              frameStart
);

	localparam int PIX_BITS = (LINE_PIXELS > 1) ? $clog2(LINE_PIXELS) : 1;
	localparam int LINE_BITS = (FRAME_LINES > 1) ? $clog2(FRAME_LINES) : 1;

	logic [PIX_BITS-1:0]    pixelCnt;
	logic [LINE_BITS-1:0]   lineCnt;
	logic                   lineEnd;
	logic                   frameEnd;

	// ====================
	// Counters

	// Last pixel of a line, last line of a frame
	assign lineEnd = pixelCnt == PIX_BITS'(LINE_PIXELS - 1);
	assign frameEnd = lineCnt == LINE_BITS'(FRAME_LINES - 1);

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			pixelCnt <= '0;
			lineCnt <= '0;
		end else begin
			// Pixel counter every cycle
			pixelCnt <= lineEnd ? '0 : pixelCnt + 1'b1;
			// Raster steps on the pixel wrap
			if (lineEnd) begin
				lineCnt <= frameEnd ? '0 : lineCnt + 1'b1;
			end
		end
	end

	// ====================
	// Decoded outputs

	// Syncs are active low at the start of line and frame
	assign HSYNC = pixelCnt >= PIX_BITS'(HSYNC_PIXELS);
	assign VSYNC = lineCnt >= LINE_BITS'(VSYNC_LINES);

	// First pixel of line zero
	assign frameStart = pixelCnt == '0 && lineCnt == '0;

	assign rasterLine = lspcPkg::RASTER_BITS'(lineCnt);

endmodule

/* autoAnim.sv */
// Auto-animation counter
module autoAnim (
	input  logic                           CLK,
	input  logic                           nRESETP,
	input  logic                           frameStart,
	input  logic [7:0]                     aaSpeed,
	output logic [lspcPkg::AA_BITS-1:0]    aaCount
);

	// Frames left before the next tile step
	logic [7:0] frameDiv;
	// Speed value the divider last saw
	logic [7:0] speedSeen;
	logic       speedChanged;

	assign speedChanged = aaSpeed != speedSeen;

	// ====================
	// Frame divider and tile counter

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			frameDiv <= '0;
			speedSeen <= '0;
			aaCount <= '0;
		end else if (frameStart) begin
			speedSeen <= aaSpeed;
			if (speedChanged) begin
				// New speed restarts the period
				frameDiv <= aaSpeed;
			end else if (frameDiv == '0) begin
				// Period is aaSpeed+1 frames
				frameDiv <= aaSpeed;
				aaCount <= aaCount + 1'b1;
			end else begin
				frameDiv <= frameDiv - 1'b1;
			end
		end
	end

endmodule

/* lspcCore.sv */
// LSPC CPU side top level
module lspcCore #(
	parameter int VRAM_ADDR_BITS = 15,
	parameter int SLOT_PERIOD = 4,
	parameter int QUEUE_DEPTH = 4,
	parameter int LINE_PIXELS = 384,
	parameter int FRAME_LINES = 264,
	parameter int HSYNC_PIXELS = 29,
	parameter int VSYNC_LINES = 8
) (
	input  logic                            CLK,
	input  logic                            nRESETP,
	input  lspcPkg::cpuBusT                 cpuBus,
	output logic                            cpuWait,
	output logic [lspcPkg::WORD_BITS-1:0]   rdData,
	output logic                            HSYNC,
	output logic                            VSYNC
);

	// Command channel
	logic                               cmdValid;
	lspcPkg::vramCmdT                   cmd;
	logic                               creditReturn;

	// Side values between blocks
	logic [lspcPkg::WORD_BITS-1:0]      vramMod;
	logic [lspcPkg::WORD_BITS-1:0]      readLatch;
	logic [7:0]                         aaSpeed;
	logic [lspcPkg::AA_BITS-1:0]        aaCount;
	logic [lspcPkg::RASTER_BITS-1:0]    rasterLine;
	logic                               frameStart;

	// ====================
	// CPU registers
	lspcRegs #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) regs (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.cpuBus(cpuBus),
		.creditReturn(creditReturn),
		.readLatch(readLatch),
		.rasterLine(rasterLine),
		.aaCount(aaCount),
		.cpuWait(cpuWait),
		.rdData(rdData),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.vramMod(vramMod),
		.aaSpeed(aaSpeed)
	);

	// ====================
	// VRAM access slots
	vramPort #(
		.VRAM_ADDR_BITS(VRAM_ADDR_BITS),
		.SLOT_PERIOD(SLOT_PERIOD),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) vport (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.vramMod(vramMod),
		.creditReturn(creditReturn),
		.readLatch(readLatch)
	);

	// Raster timing
	videoTiming #(
		.LINE_PIXELS(LINE_PIXELS),
		.FRAME_LINES(FRAME_LINES),
		.HSYNC_PIXELS(HSYNC_PIXELS),
		.VSYNC_LINES(VSYNC_LINES)
	) timing (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.HSYNC(HSYNC),
		.VSYNC(VSYNC),
		.rasterLine(rasterLine),
		.frameStart(frameStart)
	);

	// Tile animation, stepped per frame
	autoAnim anim (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.frameStart(frameStart),
		.aaSpeed(aaSpeed),
		.aaCount(aaCount)
	);

endmodule

/* tbLspcModel.svh */
// LSPC testbench reference model
`ifndef TB_LSPC_MODEL_SVH
`define TB_LSPC_MODEL_SVH

	// ====================
	// Shadow VRAM state

	logic [lspcPkg::WORD_BITS-1:0]   shadowMem [VRAM_WORDS];
	logic [TB_ADDR_BITS-1:0]         shadowPtr;
	logic [lspcPkg::WORD_BITS-1:0]   shadowMod;

	task automatic modelReset();
		foreach (shadowMem[i]) begin
			shadowMem[i] = '0;
		end
		shadowPtr = '0;
		shadowMod = '0;
	endtask

	// Pointer after a write, full modulo added then wrapped to the VRAM size
	function automatic logic [TB_ADDR_BITS-1:0] nextPtr(
		input logic [TB_ADDR_BITS-1:0] ptr,
		input logic [lspcPkg::WORD_BITS-1:0] modVal
	);
		int sum;
		sum = int'(ptr) + int'(modVal);
		return TB_ADDR_BITS'(sum % VRAM_WORDS);
	endfunction

	function automatic logic [lspcPkg::WORD_BITS-1:0] expectedRead(
		input logic [TB_ADDR_BITS-1:0] addr
	);
		return shadowMem[addr];
	endfunction

	// Raster line from bit 7 up, tile count in the low bits
	function automatic logic [lspcPkg::WORD_BITS-1:0] expectedMode(input int line, input int aa);
		return lspcPkg::WORD_BITS'(line * (1 << (lspcPkg::WORD_BITS - lspcPkg::RASTER_BITS)) + aa);
	endfunction

	// One step per speed+1 frames, 3-bit wrap
	function automatic logic [lspcPkg::AA_BITS-1:0] expectedAa(
		input int base,
		input int frames,
		input int speed
	);
		int steps;
		steps = frames / (speed + 1);
		return lspcPkg::AA_BITS'((base + steps) % (1 << lspcPkg::AA_BITS));
	endfunction

	// Shadow side of the VRAM commands
	task automatic modelSetMod(input logic [lspcPkg::WORD_BITS-1:0] modVal);
		shadowMod = modVal;
	endtask

	task automatic modelLoad(input logic [TB_ADDR_BITS-1:0] addr);
		shadowPtr = addr;
	endtask

	task automatic modelWrite(input logic [lspcPkg::WORD_BITS-1:0] data);
		shadowMem[shadowPtr] = data;
		shadowPtr = nextPtr(shadowPtr, shadowMod);
	endtask

`endif

/* tbLspc.sv */
// LSPC CPU side testbench
module tbLspc;

	// ====================
	// DUT setup and run length

	localparam int TB_ADDR_BITS = 8;
	localparam int SLOT = 4;
	localparam int DEPTH = 4;
	localparam int PIXELS = 32;
	localparam int LINES = 12;
	localparam int VRAM_WORDS = 1 << TB_ADDR_BITS;
	localparam int FRAME_CYCLES = PIXELS * LINES;
	localparam int RAND_SEED = 33766;
	localparam int BURST_MAX = 8;
	localparam int BP_WRITES = 10;
	localparam int AA_FRAMES = 10;
	// Per word: write, address load, two slots, read
	localparam int WORD_CYCLES = 3 * SLOT + 4;
	localparam int BURST_CYCLES = BURST_MAX * WORD_CYCLES + (BURST_MAX + 2) * SLOT;
	localparam int BP_CYCLES = BP_WRITES * WORD_CYCLES + (BP_WRITES + 2) * SLOT;
	// Reset, three bursts, back-pressure, timing frames, two animation runs
	localparam int TEST_CYCLES = 40 + 3 * BURST_CYCLES + BP_CYCLES + 3 * FRAME_CYCLES
		+ 2 * (AA_FRAMES + 3) * FRAME_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic                            CLK;
	logic                            nRESETP;
	lspcPkg::cpuBusT                 cpuBus;
	logic                            cpuWait;
	logic [lspcPkg::WORD_BITS-1:0]   rdData;
	logic                            HSYNC;
	logic                            VSYNC;

	int   cycleCount = 0;
	logic sawWait = 1'b0;
	// Sync edge tracking
	logic prevH = 1'b0;
	logic prevV = 1'b0;
	int   lastHFall = 0;
	int   lastVFall = 0;
	int   hFalls = 0;
	int   vFalls = 0;
	int   tbLine = 0;

	`include "tbLspcModel.svh"

	lspcCore #(
		.VRAM_ADDR_BITS(TB_ADDR_BITS),
		.SLOT_PERIOD(SLOT),
		.QUEUE_DEPTH(DEPTH),
		.LINE_PIXELS(PIXELS),
		.FRAME_LINES(LINES),
		.HSYNC_PIXELS(4),
		.VSYNC_LINES(2)
	) DUT (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.cpuBus(cpuBus),
		.cpuWait(cpuWait),
		.rdData(rdData),
		.HSYNC(HSYNC),
		.VSYNC(VSYNC)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// ====================
	// Checker, timeout, sync monitor

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d clock cycles", cycleCount);
			$display("Errors found");
			$fatal(1, "Run did not finish");
		end
	end

	// Sync periods, and the raster line counted from VSYNC
	always @(negedge CLK) begin
		if (nRESETP) begin
			if (prevH && !HSYNC) begin
				if (hFalls > 0) begin
					checkValue(cycleCount - lastHFall, PIXELS, "HSYNC fall spacing");
				end
				lastHFall = cycleCount;
				hFalls++;
				tbLine = (prevV && !VSYNC) ? 0 : tbLine + 1;
			end
			if (prevV && !VSYNC) begin
				if (vFalls > 0) begin
					checkValue(cycleCount - lastVFall, FRAME_CYCLES, "VSYNC fall spacing");
				end
				lastVFall = cycleCount;
				vFalls++;
			end
			prevH = HSYNC;
			prevV = VSYNC;
		end
	end

	// ====================
	// Bus tasks, called on a falling edge

	// Hold the write until cpuWait drops, return after it is taken
	task automatic busWrite(input lspcPkg::regSelT sel, input logic [15:0] data);
		cpuBus.sel = sel;
		cpuBus.wr = 1'b1;
		cpuBus.rd = 1'b0;
		cpuBus.wrData = data;
		#1;
		while (cpuWait) begin
			sawWait = 1'b1;
			@(negedge CLK);
			#1;
		end
		@(negedge CLK);
	endtask

	task automatic busIdle();
		cpuBus.wr = 1'b0;
		cpuBus.rd = 1'b0;
	endtask

	task automatic busRead(input lspcPkg::regSelT sel, output logic [15:0] data);
		cpuBus.sel = sel;
		cpuBus.wr = 1'b0;
		cpuBus.rd = 1'b1;
		@(negedge CLK);
		cpuBus.rd = 1'b0;
		data = rdData;
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic waitHFall();
		int start;
		start = hFalls;
		while (hFalls == start) begin
			@(negedge CLK);
		end
	endtask

	task automatic waitVFall();
		int start;
		start = vFalls;
		while (vFalls == start) begin
			@(negedge CLK);
		end
	endtask

	// DUT write plus the matching model step
	task automatic setMod(input logic [15:0] modVal);
		busWrite(lspcPkg::REG_VRAMMOD, modVal);
		modelSetMod(modVal);
	endtask

	task automatic setAddr(input logic [TB_ADDR_BITS-1:0] addr);
		busWrite(lspcPkg::REG_VRAMADDR, 16'(addr));
		modelLoad(addr);
	endtask

	// ====================
	// Test steps

	// Point at the address, let two slots pass, compare the latch
	task automatic checkWord(input logic [TB_ADDR_BITS-1:0] addr);
		logic [15:0] got;
		setAddr(addr);
		busIdle();
		waitCycles(2 * SLOT);
		busRead(lspcPkg::REG_VRAMRW, got);
		checkValue(got, expectedRead(addr), $sformatf("VRAM word at 0x%0h", addr));
	endtask

	// Random burst from start, stepped by modVal, then each word read back
	task automatic burstTest(input logic [TB_ADDR_BITS-1:0] start, input logic [15:0] modVal,
		input int count);
		logic [TB_ADDR_BITS-1:0] addrs [$];
		logic [15:0] data;
		setMod(modVal);
		setAddr(start);
		for (int i = 0; i < count; i++) begin
			addrs.push_back(shadowPtr);
			data = 16'($urandom);
			busWrite(lspcPkg::REG_VRAMRW, data);
			modelWrite(data);
		end
		busIdle();
		waitCycles((count + 2) * SLOT);
		foreach (addrs[i]) begin
			checkWord(addrs[i]);
		end
	endtask

	// Write a tile speed, then follow aaCount frame by frame
	task automatic animTest(input int speed, input int frames);
		lspcPkg::lspcModeT mode;
		logic [15:0] got;
		int base;
		mode.fields.aaSpeed = 8'(speed);
		mode.fields.reserved = '0;
		// Write well clear of a frame start
		waitVFall();
		waitCycles(8);
		busWrite(lspcPkg::REG_LSPCMODE, mode.raw);
		busIdle();
		// Next frame start reloads the divider
		waitVFall();
		waitCycles(4);
		busRead(lspcPkg::REG_LSPCMODE, got);
		base = int'(got[2:0]);
		for (int k = 1; k <= frames; k++) begin
			waitVFall();
			waitCycles(4);
			busRead(lspcPkg::REG_LSPCMODE, got);
			checkValue(got, expectedMode(0, expectedAa(base, k, speed)),
				$sformatf("mode word %0d frames after speed %0d", k, speed));
		end
	endtask

	// ====================
	// Main sequence

	initial begin : mainSeq
		logic [15:0] got;
		int startV;
		void'($urandom(RAND_SEED));
		cpuBus = '0;
		nRESETP = 1'b0;
		modelReset();
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		nRESETP = 1'b1;

		// After reset
		@(negedge CLK);
		checkValue(cpuWait, 0, "cpuWait after reset");
		checkValue(HSYNC, 0, "HSYNC after reset");
		checkValue(VSYNC, 0, "VSYNC after reset");
		checkValue(rdData, 0, "rdData after reset");
		busRead(lspcPkg::REG_VRAMADDR, got);
		checkValue(got, 0, "VRAMADDR read after reset");
		busRead(lspcPkg::REG_VRAMRW, got);
		checkValue(got, 0, "VRAMRW read after reset");
		busRead(lspcPkg::REG_VRAMMOD, got);
		checkValue(got, 0, "VRAMMOD read after reset");
		// Speed zero steps the tiles on the first frame start out of reset
		busRead(lspcPkg::REG_LSPCMODE, got);
		checkValue(got, expectedMode(0, expectedAa(0, 1, 0)), "mode read after reset");

		// Writes and read-back
		burstTest(8'($urandom), 16'($urandom % 16 + 1), 3 + $urandom % (BURST_MAX - 2));
		busRead(lspcPkg::REG_VRAMMOD, got);
		checkValue(got, shadowMod, "modulo read-back");

		// Modulo wrap, backwards and past 8 bits
		burstTest(8'($urandom), 16'hFFFF, 6);
		burstTest(8'($urandom), 16'($urandom) | 16'h0180, 6);

		// Back-pressure
		sawWait = 1'b0;
		burstTest(8'($urandom), 16'd1, BP_WRITES);
		checkValue(sawWait, 1, "cpuWait seen during back-to-back writes");

		// Video timing, periods checked by the monitor
		startV = vFalls;
		while (vFalls < startV + 3) begin
			waitHFall();
			waitCycles(8);
			busRead(lspcPkg::REG_LSPCMODE, got);
			// Raster field only
			checkValue(got & 16'hFF80, expectedMode(tbLine, 0), "raster line in mode word");
		end

		// Auto-animation
		animTest(2, AA_FRAMES);
		animTest(0, AA_FRAMES);

		$display("No errors");
		$finish;
	end

endmodule

/* lspcCore.f */
+incdir+.
lspcPkg.sv
lspcRegs.sv
vramPort.sv
videoTiming.sv
autoAnim.sv
lspcCore.sv
tbLspc.sv

/* run.sh */
#!/bin/sh
# Build and run the LSPC testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f lspcCore.f --top-module tbLspc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbLspc > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
